// File: dlx_execute.f
+incdir+dv
hw/udlx_pkg.sv
hw/dlx_alu.sv
hw/dlx_branch_unit.sv
hw/dlx_ex_register.sv
hw/dlx_execute.sv
dv/tb_dlx_execute.sv

// File: dv/tb_dlx_model.svh
// Expected-response model; include inside a module that imports udlx_pkg, brfl uses the held flags
`ifndef TB_DLX_MODEL_SVH
`define TB_DLX_MODEL_SVH

// Predicts one response from a request and the flags held before it
function automatic ex_resp_t model_execute(ex_req_t req, flags_t held);
   logic [31:0]  a;
   logic [31:0]  b;
   logic [31:0]  r;
   logic [32:0]  s;
   logic [63:0]  p;
   flags_t       f;
   logic         tk;
   ex_resp_t     exp;
   a  = req.data_a;
   b  = req.data_b;
   p  = {32'h0, a} * {32'h0, b};
   r  = '0;
   s  = '0;
   f  = '0;
   tk = 1'b0;
   if (req.opcode == op_rtype) begin
      case (req.funct)
         fn_add: begin
            r = a + b;
            // Sign-extended 33-bit sum outside the 32-bit signed range
            s = {a[31], a} + {b[31], b};
            f.overflow = (s[32] != s[31]);
         end
         fn_sub: begin
            r = a - b;
            // Same range test on the sign-extended difference
            s = {a[31], a} - {b[31], b};
            f.overflow = (s[32] != s[31]);
         end
         fn_and: r = a & b;
         fn_or:  r = a | b;
         fn_not: r = ~b;
         fn_cmp: begin
            r = a - b;
            f.equal = (a == b);
            // Differing signs decide the signed order alone
            f.above = (a[31] != b[31]) ? b[31] : (a > b);
         end
         fn_mult: begin
            r = p[31:0];
            f.overflow = (p[63:32] != 32'h0);
         end
         fn_div: begin
            r = (b == 32'h0) ? 32'h0 : a / b;
            f.error = (b == 32'h0);
         end
         default: f.error = 1'b1;
      endcase
   end else begin
      case (req.opcode)
         op_addi, op_lw, op_sw: r = a + b;
         op_subi: r = a - b;
         op_andi: r = a & b;
         op_ori:  r = a | b;
         op_beqz: tk = (a == 32'h0);
         op_bnez: tk = (a != 32'h0);
         op_brfl: tk = (held == b[3:0]);
         default: r = '0;
      endcase
   end
   exp.result       = r;
   exp.branch_taken = tk;
   // Only R-type replaces the held flags
   exp.flags        = (req.opcode == op_rtype) ? f : held;
   return exp;
endfunction

`endif

// File: dv/tb_dlx_execute.sv
// Self-checking testbench for dlx_execute; expects fixed one-cycle latency and no back-pressure
`timescale 1ns/1ps

module tb_dlx_execute;

   import udlx_pkg::*;

   `include "tb_dlx_model.svh"

   // Issue counts per test bound the run length
   localparam int planned_issues = 70 + 200 + 10 + 6 + 9 + 300;
   localparam int max_cycles     = 2 * planned_issues + 100;

   logic      clk;
   logic      rst;
   logic      issue;
   ex_req_t   ex_req;
   ex_resp_t  ex_resp;
   logic      resp_valid;

   // Model state and scoreboard
   flags_t    model_flags;
   ex_resp_t  exp_q[$];
   int        cyc_q[$];
   ex_resp_t  exp;
   int        exp_cyc;
   int        cycle;
   int        errors;
   int        passes;
   int        test_errors;
   int        issued;

   // Operation tables for directed and random picks
   opcode_e      alu_op[14];
   funct_e       alu_fn[14];
   opcode_e      any_op[10];
   logic [31:0]  corner[5];

   dlx_execute i_dlx_execute (
      .clk        (clk),
      .rst        (rst),
      .issue      (issue),
      .ex_req     (ex_req),
      .ex_resp    (ex_resp),
      .resp_valid (resp_valid)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ----------------------------------------
   // Watchdog
   // ----------------------------------------

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= max_cycles) begin
         $display("Timeout: run exceeded %0d cycles", max_cycles);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // ----------------------------------------
   // Comparison process
   // ----------------------------------------

   // Outputs are settled mid-cycle
   always @(negedge clk) begin
      if (rst && resp_valid) begin
         if (exp_q.size() == 0) begin
            $display("Response arrived with no instruction outstanding");
            errors++;
         end else begin
            exp     = exp_q.pop_front();
            exp_cyc = cyc_q.pop_front();
            assert (ex_resp.result === exp.result) passes++;
            else begin
               $display("FAILED result exp %h got %h", exp.result, ex_resp.result);
               errors++;
            end
            assert (ex_resp.branch_taken === exp.branch_taken) passes++;
            else begin
               $display("FAILED branch_taken exp %h got %h", exp.branch_taken,
                        ex_resp.branch_taken);
               errors++;
            end
            assert (ex_resp.flags === exp.flags) passes++;
            else begin
               $display("FAILED flags exp %h got %h", exp.flags, ex_resp.flags);
               errors++;
            end
            // Response must land exactly one cycle after issue
            assert (cycle == exp_cyc + 1) passes++;
            else begin
               $display("Response came %0d cycles after its issue", cycle - exp_cyc);
               errors++;
            end
         end
      end
   end

   // ----------------------------------------
   // Stimulus helpers
   // ----------------------------------------

   // Drives one instruction for one cycle and queues its prediction
   task automatic send(opcode_e op, funct_e fn, logic [31:0] a, logic [31:0] b);
      ex_req_t   req;
      ex_resp_t  pred;
      req.opcode = op;
      req.funct  = fn;
      req.data_a = a;
      req.data_b = b;
      pred = model_execute(req, model_flags);
      if (op == op_rtype) begin
         model_flags = pred.flags;
      end
      exp_q.push_back(pred);
      cyc_q.push_back(cycle);
      ex_req = req;
      issue  = 1'b1;
      @(posedge clk);
      #1;
      issue = 1'b0;
      issued++;
   endtask

   task automatic idle(int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   // Prints the per-test line
   task automatic finish_test(string name);
      $display("%s done, %0d errors", name, errors - test_errors);
      test_errors = errors;
   endtask

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------

   initial begin
      rst = 1'b0;
      issue = 1'b0;
      ex_req = '0;
      model_flags = '0;
      cycle = 0;
      errors = 0;
      passes = 0;
      test_errors = 0;
      issued = 0;
      void'($urandom(32'hc1ef));
      alu_op = '{op_rtype, op_rtype, op_rtype, op_rtype, op_rtype, op_rtype, op_rtype,
                 op_rtype, op_addi, op_subi, op_andi, op_ori, op_lw, op_sw};
      alu_fn = '{fn_add, fn_sub, fn_and, fn_or, fn_not, fn_cmp, fn_mult, fn_div,
                 fn_add, fn_add, fn_add, fn_add, fn_add, fn_add};
      any_op = '{op_rtype, op_addi, op_subi, op_andi, op_ori, op_lw, op_sw,
                 op_beqz, op_bnez, op_brfl};
      corner = '{32'h0, 32'h1, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000};
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b1;

      // Quiet outputs before any issue
      repeat (4) begin
         @(negedge clk);
         assert (resp_valid === 1'b0 && ex_resp === '0) passes++;
         else begin
            $display("Outputs not idle after reset");
            errors++;
         end
      end
      @(posedge clk);
      #1;
      finish_test("reset");

      // Corners then random pairs issued back to back
      for (int i = 0; i < 14; i++) begin
         for (int j = 0; j < 5; j++) begin
            send(alu_op[i], alu_fn[i], corner[j], corner[(j + 2) % 5]);
         end
      end
      for (int k = 0; k < 200; k++) begin
         int sel;
         sel = $urandom % 14;
         send(alu_op[sel], alu_fn[sel], $urandom, $urandom);
      end
      idle(2);
      finish_test("alu");

      // Flag corners
      send(op_rtype, fn_add, 32'h7fff_ffff, 32'h1);
      send(op_rtype, fn_add, 32'h8000_0000, 32'h8000_0000);
      send(op_rtype, fn_add, 32'hffff_ffff, 32'h1);
      send(op_rtype, fn_sub, 32'h8000_0000, 32'h1);
      send(op_rtype, fn_sub, 32'h7fff_ffff, 32'hffff_ffff);
      send(op_rtype, fn_mult, 32'h0001_0000, 32'h0001_0000);
      send(op_rtype, fn_div, 32'h5, 32'h0);
      send(op_rtype, fn_cmp, 32'h5, 32'h5);
      send(op_rtype, fn_cmp, 32'h1, 32'hffff_ffff);
      send(op_rtype, funct_e'(6'h3f), 32'h3, 32'h4);
      idle(2);
      finish_test("flags");

      // Held flags survive non-R-type and then get replaced
      send(op_rtype, fn_cmp, 32'h3, 32'h1);
      send(op_addi, fn_add, 32'h10, 32'h20);
      send(op_lw, fn_add, 32'h100, 32'h4);
      send(op_beqz, fn_add, 32'h0, 32'h0);
      send(op_rtype, fn_sub, 32'h8000_0000, 32'h1);
      send(op_ori, fn_add, 32'hf0, 32'h0f);
      idle(2);
      finish_test("persistence");

      // Branch tests with brfl right behind a cmp
      send(op_beqz, fn_add, 32'h0, 32'h0);
      send(op_beqz, fn_add, 32'h5, 32'h0);
      send(op_bnez, fn_add, 32'h0, 32'h0);
      send(op_bnez, fn_add, 32'h5, 32'h0);
      send(op_rtype, fn_cmp, 32'h2, 32'h2);
      send(op_brfl, fn_add, 32'h0, 32'h2);
      send(op_rtype, fn_cmp, 32'h9, 32'h2);
      send(op_brfl, fn_add, 32'h0, 32'h2);
      send(op_brfl, fn_add, 32'h0, 32'hf4);
      idle(2);
      finish_test("branch");

      // Mixed traffic with short random gaps
      for (int k = 0; k < 300; k++) begin
         opcode_e  op;
         funct_e   fn;
         op = ($urandom % 16 == 0) ? opcode_e'(6'($urandom)) : any_op[$urandom % 10];
         fn = ($urandom % 10 < 8) ? alu_fn[$urandom % 8] : funct_e'(6'($urandom));
         send(op, fn, $urandom, $urandom);
         idle($urandom % 2);
      end
      idle(3);
      finish_test("random mix");

      if (exp_q.size() != 0) begin
         $display("%0d responses never arrived", exp_q.size());
         errors++;
      end
      $display("Issued %0d, checks passed %0d, failed %0d", issued, passes, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: hw/dlx_alu.sv
// Purely combinational ALU; divide is single-cycle and unsigned, divide by zero returns 0
`timescale 1ns/1ps

module dlx_alu (
   input  udlx_pkg::ex_req_t                ex_req,
   output logic [udlx_pkg::data_width-1:0]  alu_result,
   output udlx_pkg::flags_t                 flags_next,
   output logic                             flags_update
);

   import udlx_pkg::*;

   // Bit index of the sign
   localparam int msb = data_width - 1;

   // ----------------------------------------
   // Shared datapath
   // ----------------------------------------

   logic [data_width-1:0]    sum_result;
   logic [data_width-1:0]    sub_result;
   logic [data_width-1:0]    and_result;
   logic [data_width-1:0]    or_result;
   logic [2*data_width-1:0]  mult_full;
   logic [data_width-1:0]    div_result;
   logic                     b_zero;
   logic                     sign_a;
   logic                     sign_b;
   logic                     add_ovf;
   logic                     sub_ovf;
   logic                     mult_ovf;

   assign sum_result = ex_req.data_a + ex_req.data_b;
   assign sub_result = ex_req.data_a - ex_req.data_b;
   assign and_result = ex_req.data_a & ex_req.data_b;
   assign or_result  = ex_req.data_a | ex_req.data_b;

   // Full 64-bit unsigned product with the result in the low half
   assign mult_full  = {{data_width{1'b0}}, ex_req.data_a} *
                       {{data_width{1'b0}}, ex_req.data_b};

   // Quotient forced to 0 on a zero divisor
   assign b_zero     = (ex_req.data_b == '0);
   assign div_result = b_zero ? '0 : (ex_req.data_a / ex_req.data_b);

   assign sign_a = ex_req.data_a[msb];
   assign sign_b = ex_req.data_b[msb];

   // Same-sign operands whose sum flips sign
   assign add_ovf  = (sign_a == sign_b) && (sum_result[msb] != sign_a);
   // Opposite-sign operands where the difference loses the sign of A
   assign sub_ovf  = (sign_a != sign_b) && (sub_result[msb] != sign_a);
   // Anything in the upper half cannot fit in the result
   assign mult_ovf = |mult_full[2*data_width-1:data_width];

   // Only R-type instructions touch the flags register
   assign flags_update = (ex_req.opcode == op_rtype);

   // ----------------------------------------
   // Result and flag select
   // ----------------------------------------

   always_comb begin
      alu_result = '0;
      flags_next = '0;
      if (ex_req.opcode == op_rtype) begin
         case (ex_req.funct)
            fn_add: begin
               alu_result          = sum_result;
               flags_next.overflow = add_ovf;
            end
            fn_sub: begin
               alu_result          = sub_result;
               flags_next.overflow = sub_ovf;
            end
            fn_and: begin
               alu_result = and_result;
            end
            fn_or: begin
               alu_result = or_result;
            end
            fn_not: begin
               // Unary op that ignores operand A
               alu_result = ~ex_req.data_b;
            end
            fn_cmp: begin
               // Difference is returned alongside the compare flags
               alu_result       = sub_result;
               flags_next.equal = (ex_req.data_a == ex_req.data_b);
               flags_next.above = ($signed(ex_req.data_a) > $signed(ex_req.data_b));
            end
            fn_mult: begin
               alu_result          = mult_full[data_width-1:0];
               flags_next.overflow = mult_ovf;
            end
            fn_div: begin
               alu_result       = div_result;
               flags_next.error = b_zero;
            end
            default: begin
               // Unknown function yields 0 and raises error
               flags_next.error = 1'b1;
            end
         endcase
      end else begin
         case (ex_req.opcode)
            // Address add for loads and stores shares the adder
            op_addi, op_lw, op_sw: alu_result = sum_result;
            op_subi:               alu_result = sub_result;
            op_andi:               alu_result = and_result;
            op_ori:                alu_result = or_result;
            // Branches and unknown opcodes
            default:               alu_result = '0;
         endcase
      end
   end

endmodule

// File: hw/dlx_branch_unit.sv
// Combinational branch test; brfl compares the held flags, not the flags of this request
`timescale 1ns/1ps

module dlx_branch_unit (
   input  udlx_pkg::ex_req_t  ex_req,
   input  udlx_pkg::flags_t   flags_q,
   output logic               taken
);

   import udlx_pkg::*;

   // Width of the flag pattern carried in the low bits of B
   localparam int flags_width = $bits(flags_t);

   logic a_zero;
   logic flags_match;

   // Zero detect on operand A
   assign a_zero = (ex_req.data_a == '0);

   // Held flags against the immediate pattern
   assign flags_match = (flags_q == ex_req.data_b[flags_width-1:0]);

   // ----------------------------------------
   // Branch decision
   // ----------------------------------------

   always_comb begin
      case (ex_req.opcode)
         op_beqz: taken = a_zero;
         op_bnez: taken = !a_zero;
         op_brfl: taken = flags_match;
         // Not a branch
         default: taken = 1'b0;
      endcase
   end

endmodule

// File: hw/dlx_ex_register.sv
// One-cycle output stage; no back-pressure, every response must be taken when resp_valid is high
`timescale 1ns/1ps

module dlx_ex_register (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             issue,
   input  logic [udlx_pkg::data_width-1:0]  alu_result,
   input  udlx_pkg::flags_t                 flags_next,
   input  logic                             flags_update,
   input  logic                             taken,
   output udlx_pkg::flags_t                 flags_q,
   output udlx_pkg::ex_resp_t               ex_resp,
   output logic                             resp_valid
);

   import udlx_pkg::*;

   logic    flags_load;
   flags_t  flags_post;

   // Flags change only for an issued R-type
   assign flags_load = issue & flags_update;

   // Flags as they stand once this instruction completes
   assign flags_post = flags_load ? flags_next : flags_q;

   // ----------------------------------------
   // Architectural flags
   // ----------------------------------------

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         flags_q <= '0;
      end else if (flags_load) begin
         flags_q <= flags_next;
      end
   end

   // ----------------------------------------
   // Response register
   // ----------------------------------------

   // Holds the last response until the next issue
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         ex_resp <= '0;
      end else if (issue) begin
         ex_resp.result       <= alu_result;
         ex_resp.branch_taken <= taken;
         ex_resp.flags        <= flags_post;
      end
   end

   // One valid pulse per issue so back-to-back issues give back-to-back pulses
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= issue;
      end
   end

endmodule

// File: hw/dlx_execute.sv
// Execute stage top; ex_req must be stable while issue is high, response follows one cycle later
`timescale 1ns/1ps

module dlx_execute (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 issue,
   input  udlx_pkg::ex_req_t    ex_req,
   output udlx_pkg::ex_resp_t   ex_resp,
   output logic                 resp_valid
);

   import udlx_pkg::*;

   // ALU to output stage
   logic [data_width-1:0]  alu_result;
   flags_t                 flags_next;
   logic                   flags_update;

   // Branch unit to output stage
   logic                   taken;

   // Held flags fed back for brfl
   flags_t                 flags_q;

   // ----------------------------------------
   // Parallel datapaths on the same request
   // ----------------------------------------

   dlx_alu i_dlx_alu (
      .ex_req       (ex_req),
      .alu_result   (alu_result),
      .flags_next   (flags_next),
      .flags_update (flags_update)
   );

   dlx_branch_unit i_dlx_branch_unit (
      .ex_req  (ex_req),
      .flags_q (flags_q),
      .taken   (taken)
   );

   // Registered response and flags state
   dlx_ex_register i_dlx_ex_register (
      .clk          (clk),
      .rst          (rst),
      .issue        (issue),
      .alu_result   (alu_result),
      .flags_next   (flags_next),
      .flags_update (flags_update),
      .taken        (taken),
      .flags_q      (flags_q),
      .ex_resp      (ex_resp),
      .resp_valid   (resp_valid)
   );

endmodule

// File: hw/udlx_pkg.sv
// Shared types for the execute stage; multiply and divide are unsigned, opcodes are DLX-style
package udlx_pkg;

   // ----------------------------------------
   // Widths
   // ----------------------------------------

   // Operand and result width
   localparam int data_width   = 32;
   // Instruction opcode field
   localparam int opcode_width = 6;
   // R-type function field
   localparam int funct_width  = 6;

   // ----------------------------------------
   // Encodings
   // ----------------------------------------

   // Primary opcodes handled by the execute stage
   typedef enum logic [opcode_width-1:0] {
      op_rtype = 6'h00,
      op_beqz  = 6'h04,
      op_bnez  = 6'h05,
      op_brfl  = 6'h06,
      op_addi  = 6'h08,
      op_subi  = 6'h0A,
      op_andi  = 6'h0C,
      op_ori   = 6'h0D,
      op_lw    = 6'h23,
      op_sw    = 6'h2B
   } opcode_e;

   // R-type function codes
   typedef enum logic [funct_width-1:0] {
      fn_mult = 6'h18,
      fn_div  = 6'h1A,
      fn_add  = 6'h20,
      fn_sub  = 6'h22,
      fn_and  = 6'h24,
      fn_or   = 6'h25,
      fn_not  = 6'h27,
      fn_cmp  = 6'h2A
   } funct_e;

   // ----------------------------------------
   // Bundles
   // ----------------------------------------

   // Condition flags in the packed order of the brfl pattern in B[3:0]
   typedef struct packed {
      logic overflow;
      logic above;
      logic equal;
      logic error;
   } flags_t;

   // Decoded instruction with both operands in 76 bits
   typedef struct packed {
      opcode_e                opcode;
      funct_e                 funct;
      logic [data_width-1:0]  data_a;
      logic [data_width-1:0]  data_b;
   } ex_req_t;

   // Registered execute result of 37 bits
   typedef struct packed {
      logic [data_width-1:0]  result;
      logic                   branch_taken;
      flags_t                 flags;
   } ex_resp_t;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f dlx_execute.f \
   --top-module tb_dlx_execute \
   -o sim_dlx_execute

sim_output=$(./obj_dir/sim_dlx_execute)
echo "$sim_output"

if echo "$sim_output" | grep -qF -- "*** TEST PASSED ***"; then
   exit 0
else
   exit 1
fi
